/* design/nnPkg.sv */
`default_nettype none

package nnPkg;

	localparam int actWidth = 8;
	localparam int weightWidth = 8;
	localparam int biasWidth = 16; // Same scale as a product
	localparam int accWidth = 23;
	localparam int fracShift = 6; // Sum is scaled down by 64
	localparam int actMax = 127;

	localparam int numFeatures = 8;
	localparam int numHidden = 15;
	localparam int numClasses = 4;
	localparam int classWidth = 2;

	localparam int nodeLatency = 3; // Input reg, sum reg, output reg
	localparam int topLatency = 2 * nodeLatency + 1;

	// Row n holds the weights of hidden neuron n, column i meets feature i
	localparam logic [0:numHidden-1][0:numFeatures-1][weightWidth-1:0] hiddenWeights = '{
		'{ 8'sd24, -8'sd40,  8'sd30,  8'sd8,   8'sd36, -8'sd56, -8'sd6,   8'sd32},
		'{-8'sd18,  8'sd22,  8'sd40, -8'sd12,  8'sd6,   8'sd28, -8'sd34,  8'sd10},
		'{ 8'sd32,  8'sd16, -8'sd8,  -8'sd24,  8'sd44,  8'sd2,  -8'sd14,  8'sd20},
		'{-8'sd50, -8'sd12,  8'sd26,  8'sd38, -8'sd4,   8'sd18,  8'sd8,  -8'sd30},
		'{ 8'sd12,  8'sd34, -8'sd22,  8'sd6,  -8'sd16,  8'sd40,  8'sd24, -8'sd8},
		'{-8'sd6,  -8'sd28,  8'sd14,  8'sd52,  8'sd20, -8'sd10, -8'sd36,  8'sd16},
		'{ 8'sd40,  8'sd8,  -8'sd18, -8'sd2,  -8'sd26,  8'sd30,  8'sd12,  8'sd36},
		'{-8'sd24,  8'sd46,  8'sd6,  -8'sd32,  8'sd10, -8'sd14,  8'sd28,  8'sd4},
		'{ 8'sd18, -8'sd8,  -8'sd42,  8'sd20,  8'sd34,  8'sd6,  -8'sd20,  8'sd26},
		'{ 8'sd2,   8'sd30,  8'sd16, -8'sd44, -8'sd12,  8'sd24,  8'sd38, -8'sd18},
		'{-8'sd36, -8'sd4,   8'sd20,  8'sd14,  8'sd48, -8'sd22,  8'sd6,   8'sd10},
		'{ 8'sd28, -8'sd20, -8'sd10,  8'sd36, -8'sd6,   8'sd12, -8'sd30,  8'sd42},
		'{-8'sd12,  8'sd14,  8'sd34, -8'sd16,  8'sd22, -8'sd40,  8'sd18, -8'sd2},
		'{ 8'sd8,  -8'sd34, -8'sd26,  8'sd10,  8'sd30,  8'sd44, -8'sd8,  -8'sd14},
		'{ 8'sd32,  8'sd20,  8'sd12, -8'sd28, -8'sd38,  8'sd4,   8'sd16, -8'sd6}
	};

	// Multiples of 64 and never positive, so a zero input settles to zero
	localparam logic [0:numHidden-1][biasWidth-1:0] hiddenBias = '{
		-16'sd512, -16'sd128, -16'sd64,  16'sd0,   -16'sd256,
		-16'sd192, -16'sd64,  -16'sd320, 16'sd0,   -16'sd128,
		-16'sd448, -16'sd64,  -16'sd192, -16'sd256, -16'sd128
	};

	localparam logic [0:numClasses-1][0:numHidden-1][weightWidth-1:0] outWeights = '{
		'{ 8'sd20, -8'sd14,  8'sd8,   8'sd30, -8'sd22,  8'sd12, -8'sd6,   8'sd18,
		  -8'sd10,  8'sd26,  8'sd4,  -8'sd16,  8'sd14, -8'sd8,   8'sd22},
		'{-8'sd12,  8'sd24, -8'sd18,  8'sd6,   8'sd16, -8'sd28,  8'sd20, -8'sd4,
		   8'sd30, -8'sd10,  8'sd14,  8'sd8,  -8'sd22,  8'sd18, -8'sd6},
		'{ 8'sd10,  8'sd6,   8'sd28, -8'sd20, -8'sd8,   8'sd18, -8'sd24,  8'sd14,
		   8'sd4,  -8'sd16,  8'sd26, -8'sd12,  8'sd10,  8'sd22, -8'sd30},
		'{-8'sd22,  8'sd16, -8'sd6,   8'sd12,  8'sd24, -8'sd10,  8'sd8,  -8'sd26,
		   8'sd18,  8'sd6,  -8'sd14,  8'sd28, -8'sd4,  -8'sd18,  8'sd12}
	};

	localparam logic [0:numClasses-1][biasWidth-1:0] outBias = '{
		-16'sd256, -16'sd128, -16'sd320, -16'sd64
	};

endpackage

`default_nettype wire

/* design/neuronNode.sv */
`timescale 1ns/10ps
`default_nettype none

module neuronNode
	import nnPkg::*;
#(
	parameter int fanIn = numFeatures,
	parameter logic [0:fanIn-1][weightWidth-1:0] weights = '0,
	parameter logic [biasWidth-1:0] bias = '0
)
(
	input wire clk,
	input wire reset,
	input wire [fanIn-1:0][actWidth-1:0] acts,
	output logic [actWidth-1:0] act
);

	localparam logic signed [accWidth-1:0] roundHalf = accWidth'(1 <<< (fracShift - 1));

	logic [fanIn-1:0][actWidth-1:0] actsReg;
	logic signed [actWidth+weightWidth-1:0] products [fanIn];
	logic signed [accWidth-1:0] sumNext;
	logic signed [accWidth-1:0] sumReg;
	logic signed [accWidth-1:0] scaled;

	// One signed product per input, all from the registered vector
	always_comb
	begin
		for (int i = 0; i < fanIn; i++)
		begin
			products[i] = $signed(actsReg[i]) * $signed(weights[i]);
		end
	end

	always_comb
	begin
		sumNext = accWidth'($signed(bias)); // Bias sign-extended
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + accWidth'(products[i]);
		end
	end

	// Round half up, then drop the fraction bits
	assign scaled = (sumReg + roundHalf) >>> fracShift;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actsReg <= '0;
			sumReg <= '0;
			act <= '0;
		end
		else
		begin
			actsReg <= acts; // Stage 1
			sumReg <= sumNext; // Stage 2
			if (scaled < 0)
			begin
				act <= '0; // ReLU
			end
			else if (scaled > actMax)
			begin
				act <= actWidth'(actMax); // Saturate
			end
			else
			begin
				act <= scaled[actWidth-1:0];
			end
		end
	end

	// Clamp sits after rounding, so 127 plus a half step cannot leak through
	actInRange: assert property (
		@(posedge clk) disable iff (reset)
		act <= actWidth'(actMax)
	)
	else
		$error("neuronNode activation %0d above ceiling", act);

endmodule

`default_nettype wire

/* design/denseLayer.sv */
`timescale 1ns/10ps
`default_nettype none

module denseLayer
	import nnPkg::*;
#(
	parameter int fanIn = numFeatures,
	parameter int numNodes = numHidden,
	parameter logic [0:numNodes-1][0:fanIn-1][weightWidth-1:0] weights = '0,
	parameter logic [0:numNodes-1][biasWidth-1:0] bias = '0
)
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire [fanIn-1:0][actWidth-1:0] acts,
	output logic outValid,
	output logic [numNodes-1:0][actWidth-1:0] outActs
);

	logic [nodeLatency-1:0] validPipe;

	// Every neuron sees the same vector and takes its own weight row
	for (genvar n = 0; n < numNodes; n++)
	begin : gNode
		neuronNode #(
			.fanIn(fanIn),
			.weights(weights[n]),
			.bias(bias[n])
		) node (
			.clk(clk),
			.reset(reset),
			.acts(acts),
			.act(outActs[n])
		);
	end

	// Strobe follows the data through the neuron pipeline
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[nodeLatency-2:0], inValid};
		end
	end

	assign outValid = validPipe[nodeLatency-1];

	quietAfterReset: assert property (
		@(posedge clk) disable iff (reset)
		$fell(reset) |-> !outValid [*nodeLatency]
	)
	else
		$error("denseLayer strobe raised too early after reset");

endmodule

`default_nettype wire

/* design/classSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module classSelect
	import nnPkg::*;
#(
	parameter int numScores = numClasses
)
(
	input wire clk,
	input wire reset,
	input wire scoreValid,
	input wire [numScores-1:0][actWidth-1:0] scores,
	output logic classValid,
	output logic [classWidth-1:0] classIdx,
	output logic [actWidth-1:0] classScore
);

	logic [classWidth-1:0] bestIdx;
	logic [actWidth-1:0] bestScore;

	function automatic logic [actWidth-1:0] scoreAt(
		input logic [numScores-1:0][actWidth-1:0] s,
		input logic [classWidth-1:0] k
	);
		return s[k];
	endfunction

	// Strictly greater, so a tie keeps the lower index
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int i = 1; i < numScores; i++)
		begin
			if (scores[i] > bestScore)
			begin
				bestIdx = classWidth'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classValid <= 1'b0;
			classIdx <= '0;
			classScore <= '0;
		end
		else
		begin
			classValid <= scoreValid;
			if (scoreValid)
			begin
				classIdx <= bestIdx; // Held until the next vector
				classScore <= bestScore;
			end
		end
	end

	winnerMatches: assert property (
		@(posedge clk) disable iff (reset)
		classValid |-> classScore == scoreAt($past(scores), classIdx)
	)
	else
		$error("classSelect score %0d does not match index %0d", classScore, classIdx);

endmodule

`default_nettype wire

/* design/mlpTop.sv */
`timescale 1ns/10ps
`default_nettype none

module mlpTop
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire [numFeatures-1:0][actWidth-1:0] features,
	output wire scoreValid,
	output wire [numClasses-1:0][actWidth-1:0] scores,
	output wire classValid,
	output wire [classWidth-1:0] classIdx,
	output wire [actWidth-1:0] classScore
);

	wire hiddenValid;
	wire [numHidden-1:0][actWidth-1:0] hiddenActs;

	denseLayer #(
		.fanIn(numFeatures),
		.numNodes(numHidden),
		.weights(hiddenWeights),
		.bias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.acts(features),
		.outValid(hiddenValid),
		.outActs(hiddenActs)
	);

	// Hidden activations are 0..127, so they read the same as signed inputs
	denseLayer #(
		.fanIn(numHidden),
		.numNodes(numClasses),
		.weights(outWeights),
		.bias(outBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.acts(hiddenActs),
		.outValid(scoreValid),
		.outActs(scores)
	);

	classSelect #(
		.numScores(numClasses)
	) classSelect_inst (
		.clk(clk),
		.reset(reset),
		.scoreValid(scoreValid),
		.scores(scores),
		.classValid(classValid),
		.classIdx(classIdx),
		.classScore(classScore)
	);

endmodule

`default_nettype wire

/* verification/mlpRefModel.svh */
`ifndef MLP_REF_MODEL_SVH
`define MLP_REF_MODEL_SVH

// Neuron rule: add half a step, divide by 64, keep 0..127
function automatic int scaleAndClamp(input int sum);
	int t;
	int q;
	t = sum + (1 << (fracShift - 1));
	if (t < 0)
		return 0; // Any negative quotient clamps to zero
	q = t / (1 << fracShift);
	return (q > actMax) ? actMax : q;
endfunction

function automatic logic [numHidden-1:0][actWidth-1:0] hiddenOut(
	input logic [numFeatures-1:0][actWidth-1:0] f
);
	logic [numHidden-1:0][actWidth-1:0] h;
	int sum;
	int a;
	int w;
	for (int n = 0; n < numHidden; n++)
	begin
		sum = $signed(hiddenBias[n]);
		for (int i = 0; i < numFeatures; i++)
		begin
			a = $signed(f[i]); // Features are signed
			w = $signed(hiddenWeights[n][i]);
			sum = sum + a * w;
		end
		h[n] = actWidth'(scaleAndClamp(sum));
	end
	return h;
endfunction

function automatic logic [numClasses-1:0][actWidth-1:0] networkScores(
	input logic [numFeatures-1:0][actWidth-1:0] f
);
	logic [numHidden-1:0][actWidth-1:0] h;
	logic [numClasses-1:0][actWidth-1:0] s;
	int sum;
	int w;
	h = hiddenOut(f);
	for (int c = 0; c < numClasses; c++)
	begin
		sum = $signed(outBias[c]);
		for (int i = 0; i < numHidden; i++)
		begin
			w = $signed(outWeights[c][i]);
			sum = sum + int'(h[i]) * w;
		end
		s[c] = actWidth'(scaleAndClamp(sum));
	end
	return s;
endfunction

// Lowest index wins a tie
function automatic int bestClass(input logic [numClasses-1:0][actWidth-1:0] s);
	int best;
	best = 0;
	for (int c = 1; c < numClasses; c++)
	begin
		if (int'(s[c]) > int'(s[best]))
			best = c;
	end
	return best;
endfunction

`endif

/* verification/mlpTb.sv */
`timescale 1ns/10ps
`default_nettype none

module mlpTb
	import nnPkg::*;
();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 5;
	localparam int quietCycles = topLatency;
	localparam int numDirected = 5;
	localparam int numRandom = 40;
	localparam int numGaps = numRandom / 8;
	localparam int watchdogCycles = resetCycles + quietCycles + numDirected + numRandom
		+ numGaps + topLatency + 20;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic [numFeatures-1:0][actWidth-1:0] features;
	wire scoreValid;
	wire [numClasses-1:0][actWidth-1:0] scores;
	wire classValid;
	wire [classWidth-1:0] classIdx;
	wire [actWidth-1:0] classScore;

	integer seed;
	int mismatchCount = 0;
	int failureCount = 0;
	int vectorCount = 0;
	logic quietPhase = 1'b0;

	logic [numClasses-1:0][actWidth-1:0] scoreQ[$];
	logic [classWidth+actWidth-1:0] classQ[$]; // {index, winning score}
	logic [numClasses-1:0][actWidth-1:0] expScores = '0;
	logic [classWidth-1:0] expIdx = '0;
	logic [actWidth-1:0] expBest = '0;
	logic scoreExpected = 1'b0;
	logic classExpected = 1'b0;

	`include "mlpRefModel.svh"

	mlpTop mlpTop_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.features(features),
		.scoreValid(scoreValid),
		.scores(scores),
		.classValid(classValid),
		.classIdx(classIdx),
		.classScore(classScore)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Head of each queue is loaded mid-cycle, ready for the next rising edge
	always @(negedge clk)
	begin
		scoreExpected = 1'b0;
		classExpected = 1'b0;
		if (scoreValid && scoreQ.size() > 0)
		begin
			expScores = scoreQ.pop_front();
			scoreExpected = 1'b1;
		end
		if (classValid && classQ.size() > 0)
		begin
			{expIdx, expBest} = classQ.pop_front();
			classExpected = 1'b1;
		end
	end

	quietStrobes: assert property (@(posedge clk) quietPhase |-> !scoreValid && !classValid)
	else
	begin
		failureCount++;
		$display("Strobe raised at %0t during reset or idle time", $time);
	end

	quietData: assert property (@(posedge clk)
		quietPhase |-> scores == '0 && classIdx == '0 && classScore == '0)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: {scores,classIdx,classScore} expected 0 got %h", $time,
			{$sampled(scores), $sampled(classIdx), $sampled(classScore)});
	end

	scoreLatency: assert property (@(posedge clk) disable iff (reset)
		scoreValid == $past(inValid, 2 * nodeLatency))
	else
	begin
		failureCount++;
		$display("scoreValid at %0t is out of step with inValid 6 cycles earlier", $time);
	end

	classLatency: assert property (@(posedge clk) disable iff (reset)
		classValid == $past(inValid, topLatency))
	else
	begin
		failureCount++;
		$display("classValid at %0t is out of step with inValid 7 cycles earlier", $time);
	end

	scoreKnown: assert property (@(posedge clk) disable iff (reset) scoreValid |-> scoreExpected)
	else
	begin
		failureCount++;
		$display("Unexpected scoreValid at %0t with no vector waiting", $time);
	end

	classKnown: assert property (@(posedge clk) disable iff (reset) classValid |-> classExpected)
	else
	begin
		failureCount++;
		$display("Unexpected classValid at %0t with no vector waiting", $time);
	end

	scoresMatch: assert property (@(posedge clk) disable iff (reset)
		scoreValid && scoreExpected |-> scores == expScores)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: scores expected %h got %h", $time,
			$sampled(expScores), $sampled(scores));
	end

	classIdxMatch: assert property (@(posedge clk) disable iff (reset)
		classValid && classExpected |-> classIdx == expIdx)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: classIdx expected %0d got %0d", $time,
			$sampled(expIdx), $sampled(classIdx));
	end

	classScoreMatch: assert property (@(posedge clk) disable iff (reset)
		classValid && classExpected |-> classScore == expBest)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: classScore expected %0d got %0d", $time,
			$sampled(expBest), $sampled(classScore));
	end

	// Drives one vector, queues its expected results, returns 2 ns after the next edge
	task automatic sendVector(input logic [numFeatures-1:0][actWidth-1:0] f);
		logic [numClasses-1:0][actWidth-1:0] s;
		int best;
		s = networkScores(f);
		best = bestClass(s);
		inValid = 1'b1;
		features = f;
		scoreQ.push_back(s);
		classQ.push_back({classWidth'(best), s[best]});
		vectorCount++;
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	task automatic idleCycle();
		inValid = 1'b0;
		@(posedge clk);
		#2;
	endtask

	task automatic makeRandom(output logic [numFeatures-1:0][actWidth-1:0] f);
		for (int i = 0; i < numFeatures; i++)
		begin
			f[i] = actWidth'($random(seed));
		end
	endtask

	initial
	begin
		logic [numFeatures-1:0][actWidth-1:0] f;
		seed = 6;
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;
		@(posedge clk);
		#2 quietPhase = 1'b1; // Registers hold defined values from here on
		repeat (resetCycles - 1) @(posedge clk);
		#2 reset = 1'b0;
		repeat (quietCycles) @(posedge clk);
		#2 quietPhase = 1'b0;

		sendVector('0); // All-zero scores, tie goes to index 0
		sendVector({numFeatures{8'h7f}}); // Saturates some neurons
		sendVector({numFeatures{8'h80}}); // Drives others to zero
		f = '0;
		f[1] = 8'd6; // Hidden neuron 2 sums to exactly half a step
		sendVector(f);
		f = '0;
		f[3] = 8'd1;
		f[5] = 8'd21; // Hidden neuron 3 sums to 6.5 steps
		sendVector(f);

		for (int v = 0; v < numRandom; v++)
		begin
			if (v % 8 == 7)
				idleCycle();
			makeRandom(f);
			sendVector(f);
		end

		for (int i = 0; i < topLatency + 5 && (scoreQ.size() > 0 || classQ.size() > 0); i++)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (scoreQ.size() > 0 || classQ.size() > 0)
		begin
			failureCount++;
			$display("%0d score and %0d class results never got their strobe",
				scoreQ.size(), classQ.size());
		end

		$display("Summary: %0d vectors, %0d mismatches, %0d other failures",
			vectorCount, mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles before the run completed", watchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
design/nnPkg.sv
design/neuronNode.sv
design/denseLayer.sv
design/classSelect.sv
design/mlpTop.sv
verification/mlpTb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mlpTb -f flist.f -o mlpSim \
	&& ./obj_dir/mlpSim | tee sim.log \
	&& grep -q "^ALL TESTS PASSED$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
